//--- Bender.yml
package:
  name: ceres_fabric

sources:
  # RTL in compile order
  - ceres_pkg.sv
  - wb_if.sv
  - wb_decoder.sv
  - line_ram.sv
  - wb_ram_adapter.sv
  - wb_clint.sv
  - ceres_fabric.sv
  # Testbench
  - target: test
    files:
      - tb_ceres_fabric.sv

//--- ceres_fabric.f
ceres_pkg.sv
wb_if.sv
wb_decoder.sv
line_ram.sv
wb_ram_adapter.sv
wb_clint.sv
ceres_fabric.sv
tb_ceres_fabric.sv

//--- ceres_fabric.sv
`timescale 1ns/1ps

module ceres_fabric import ceres_pkg::*; #(
  parameter int unsigned RAM_LINES   = 256,
  parameter int unsigned RAM_LATENCY = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,

  // Wishbone master port
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  data_t wb_dat_i,
  input  sel_t  wb_sel_i,
  input  cti_t  wb_cti_i,
  output data_t wb_dat_o,
  output logic  wb_ack_o,
  output logic  wb_err_o,

  // CLINT interrupts
  output logic  timer_irq_o,
  output logic  sw_irq_o
);

  wb_if m_bus ();
  wb_if ram_bus ();
  wb_if clint_bus ();

  // ======================================================================
  // Top-level ports onto the master bus
  // ======================================================================

  assign m_bus.cyc   = wb_cyc_i;
  assign m_bus.stb   = wb_stb_i;
  assign m_bus.we    = wb_we_i;
  assign m_bus.adr   = wb_adr_i;
  assign m_bus.dat_w = wb_dat_i;
  assign m_bus.sel   = wb_sel_i;
  assign m_bus.cti   = wb_cti_i;

  assign wb_dat_o = m_bus.dat_r;
  assign wb_ack_o = m_bus.ack;
  assign wb_err_o = m_bus.err;

  // Address decode, no added cycles
  wb_decoder u_decoder (
    .m_bus     (m_bus),
    .ram_bus   (ram_bus),
    .clint_bus (clint_bus)
  );

  // Main RAM at 0x8000_0000
  wb_ram_adapter #(
    .RAM_LINES   (RAM_LINES),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (ram_bus)
  );

  // CLINT at 0x3000_0000
  wb_clint u_clint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bus         (clint_bus),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

endmodule

//--- ceres_pkg.sv
package ceres_pkg;

  // ======================================================================
  // Bus types
  // ======================================================================

  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  data_t;
  typedef logic [3:0]   sel_t;
  typedef logic [127:0] line_t;
  typedef logic [15:0]  line_strb_t;
  typedef logic [2:0]   cti_t;
  typedef logic [63:0]  mtime_t;

  // Wishbone cycle type identifiers
  localparam cti_t CTI_CLASSIC = 3'b000;
  localparam cti_t CTI_INCR    = 3'b010;
  localparam cti_t CTI_EOB     = 3'b111;

  // ======================================================================
  // Address map and line geometry
  // ======================================================================

  // Compared against adr[31:28]
  localparam logic [3:0] RAM_REGION   = 4'h8;
  localparam logic [3:0] CLINT_REGION = 4'h3;

  localparam int unsigned WORDS_PER_LINE = 4;
  // Byte offset bits inside a 16-byte line
  localparam int unsigned LINE_OFFSET_W  = 4;

  // CLINT register offsets, low 16 address bits
  localparam logic [15:0] CLINT_MSIP_OFF        = 16'h0000;
  localparam logic [15:0] CLINT_MTIMECMP_LO_OFF = 16'h4000;
  localparam logic [15:0] CLINT_MTIMECMP_HI_OFF = 16'h4004;
  localparam logic [15:0] CLINT_MTIME_LO_OFF    = 16'hBFF8;
  localparam logic [15:0] CLINT_MTIME_HI_OFF    = 16'hBFFC;

  // RAM adapter FSM
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    BURST
  } burst_state_e;

endpackage

//--- line_ram.sv
`timescale 1ns/1ps

module line_ram import ceres_pkg::*; #(
  parameter int unsigned RAM_LINES = 256
) (
  input  logic                         clk_i,
  input  logic [$clog2(RAM_LINES)-1:0] line_idx_i,
  input  line_t                        wdata_i,
  input  line_strb_t                   wstrb_i,
  input  logic                         rd_en_i,
  output line_t                        rdata_o
);

  localparam int unsigned BYTES_PER_LINE = $bits(line_strb_t);

  // Line storage, contents survive reset
  line_t mem [RAM_LINES];

  // Byte-granular write
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < BYTES_PER_LINE; b++) begin
      if (wstrb_i[b]) begin
        mem[line_idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // Registered read
  // Output holds its last value while rd_en_i is low
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_o <= mem[line_idx_i];
    end
  end

endmodule

//--- tb_ceres_fabric.sv
`timescale 1ns/1ps

module tb_ceres_fabric import ceres_pkg::*; ;

  localparam int unsigned RAM_LINES    = 256;
  localparam int unsigned RAM_LATENCY  = 4;
  localparam int unsigned HALF_NS      = 10;
  localparam int unsigned PERIOD_NS    = 2 * HALF_NS;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned NUM_WORDS    = 16;
  localparam int unsigned MAX_WAIT     = 64;
  // Edges from presentation until a RAM read ack shows
  // Edge 0 counts as the first
  localparam int unsigned RD_EDGES     = RAM_LATENCY + 2;
  // Rough cycle count of all tests together
  localparam int unsigned EST_CYCLES   = RESET_CYCLES + 6 * NUM_WORDS
                                       + (NUM_WORDS + 8) * (RD_EDGES + 2) + 150;
  localparam int unsigned WATCHDOG_NS  = 20 * EST_CYCLES * PERIOD_NS;

  localparam addr_t RAM_BASE   = 32'h8000_0000;
  localparam addr_t CLINT_BASE = 32'h3000_0000;
  localparam addr_t UNMAPPED   = 32'h1000_0000;

  logic  clk_i;
  logic  rst_ni;
  logic  wb_cyc_i;
  logic  wb_stb_i;
  logic  wb_we_i;
  addr_t wb_adr_i;
  data_t wb_dat_i;
  sel_t  wb_sel_i;
  cti_t  wb_cti_i;
  data_t wb_dat_o;
  logic  wb_ack_o;
  logic  wb_err_o;
  logic  timer_irq_o;
  logic  sw_irq_o;

  logic [31:0] lfsr_q;
  int unsigned mismatch_count;
  int unsigned fault_count;
  // Word-wide image of the RAM
  data_t       ram_model [RAM_LINES*WORDS_PER_LINE];

  ceres_fabric #(
    .RAM_LINES   (RAM_LINES),
    .RAM_LATENCY (RAM_LATENCY)
  ) DUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_cti_i    (wb_cti_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

  initial clk_i = 1'b0;
  always #(HALF_NS) clk_i = ~clk_i;

  // ======================================================================
  // Helpers
  // ======================================================================

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1
  // One step per bit taken
  function automatic logic [31:0] next_rand(input int unsigned nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
    mismatch_count++;
    $display("FAIL %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
  endtask

  task automatic fault(input string what);
    fault_count++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic drive_idle();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_cti_i = CTI_CLASSIC;
  endtask

  task automatic drive_req(input logic we, input addr_t adr, input data_t dat,
                           input sel_t sel, input cti_t cti);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_cti_i = cti;
  endtask

  // Samples a quarter period after each falling edge
  // Counts the rising edges passed
  task automatic await_response(output int unsigned edges);
    int unsigned n;
    n = 0;
    #(HALF_NS / 2);
    while (!(wb_ack_o || wb_err_o) && (n < MAX_WAIT)) begin
      @(negedge clk_i);
      #(HALF_NS / 2);
      n++;
    end
    if (!(wb_ack_o || wb_err_o)) fault("no ack or err before the wait limit");
    edges = n;
  endtask

  task automatic idle(input int unsigned cycles);
    repeat (cycles) @(negedge clk_i);
  endtask

  // ======================================================================
  // Bus transfers
  // ======================================================================

  task automatic write_word(input addr_t adr, input data_t dat, input sel_t sel,
                            input int unsigned exp_edges);
    int unsigned edges;
    drive_req(1'b1, adr, dat, sel, CTI_CLASSIC);
    await_response(edges);
    if (wb_err_o) fault("write answered with err");
    if (edges != exp_edges) mismatch("write ack edges", exp_edges, edges);
    @(posedge clk_i);
    @(negedge clk_i);
    drive_idle();
  endtask

  task automatic read_word(input addr_t adr, input int unsigned exp_edges,
                           output data_t data);
    int unsigned edges;
    drive_req(1'b0, adr, '0, 4'hf, CTI_CLASSIC);
    await_response(edges);
    data = wb_dat_o;
    if (wb_err_o) fault("read answered with err");
    if (edges != exp_edges) mismatch("read ack edges", exp_edges, edges);
    @(posedge clk_i);
    @(negedge clk_i);
    drive_idle();
  endtask

  // Four beats from word 0
  // Only the first beat waits for the fetch
  task automatic burst_read(input int unsigned first_idx);
    int unsigned edges;
    int unsigned exp_edges;
    cti_t        cti;
    for (int b = 0; b < WORDS_PER_LINE; b++) begin
      cti       = (b == WORDS_PER_LINE - 1) ? CTI_EOB : CTI_INCR;
      exp_edges = (b == 0) ? RD_EDGES : 0;
      drive_req(1'b0, RAM_BASE + ((first_idx + b) << 2), '0, 4'hf, cti);
      await_response(edges);
      if (wb_err_o) fault("burst beat answered with err");
      if (edges != exp_edges) mismatch("burst ack edges", exp_edges, edges);
      if (wb_dat_o !== ram_model[first_idx + b]) begin
        mismatch("wb_dat_o", ram_model[first_idx + b], wb_dat_o);
      end
      @(posedge clk_i);
      @(negedge clk_i);
    end
    drive_idle();
  endtask

  // ======================================================================
  // Tests
  // ======================================================================

  task automatic ram_byte_writes();
    int unsigned idx [NUM_WORDS];
    data_t       dat;
    sel_t        sel;
    data_t       got;
    for (int i = 0; i < NUM_WORDS; i++) begin
      idx[i] = next_rand(10);
      dat    = next_rand(32);
      write_word(RAM_BASE + (idx[i] << 2), dat, 4'hf, 0);
      ram_model[idx[i]] = dat;
    end
    // Partial writes keep the unselected bytes
    for (int i = 0; i < NUM_WORDS; i++) begin
      dat = next_rand(32);
      sel = sel_t'(next_rand(4));
      write_word(RAM_BASE + (idx[i] << 2), dat, sel, 0);
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) ram_model[idx[i]][b*8 +: 8] = dat[b*8 +: 8];
      end
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      read_word(RAM_BASE + (idx[i] << 2), RD_EDGES, got);
      if (got !== ram_model[idx[i]]) mismatch("wb_dat_o", ram_model[idx[i]], got);
    end
  endtask

  task automatic single_read_latency();
    data_t dat;
    data_t got;
    dat = next_rand(32);
    write_word(RAM_BASE + 32'h0000_0a04, dat, 4'hf, 0);
    ram_model[32'h0a04 >> 2] = dat;
    read_word(RAM_BASE + 32'h0000_0a04, RD_EDGES, got);
    if (got !== dat) mismatch("wb_dat_o", dat, got);
  endtask

  task automatic four_beat_burst();
    int unsigned first_idx;
    data_t       dat;
    data_t       got;
    first_idx = 200 * WORDS_PER_LINE;
    for (int b = 0; b < WORDS_PER_LINE; b++) begin
      dat = next_rand(32);
      write_word(RAM_BASE + ((first_idx + b) << 2), dat, 4'hf, 0);
      ram_model[first_idx + b] = dat;
    end
    burst_read(first_idx);
    // Full latency again means the adapter went back to IDLE
    read_word(RAM_BASE + ((first_idx + 1) << 2), RD_EDGES, got);
    if (got !== ram_model[first_idx + 1]) mismatch("wb_dat_o", ram_model[first_idx + 1], got);
  endtask

  task automatic timer_irq_check();
    data_t       t0;
    data_t       t1;
    data_t       now;
    int unsigned n;
    read_word(CLINT_BASE + CLINT_MTIME_LO_OFF, 1, t0);
    idle(10);
    read_word(CLINT_BASE + CLINT_MTIME_LO_OFF, 1, t1);
    if (t1 - t0 < 10) fault("mtime advanced less than the idle gap");
    // High word first so the compare never passes early
    write_word(CLINT_BASE + CLINT_MTIMECMP_HI_OFF, 32'h0, 4'hf, 1);
    read_word(CLINT_BASE + CLINT_MTIME_LO_OFF, 1, now);
    write_word(CLINT_BASE + CLINT_MTIMECMP_LO_OFF, now + 20, 4'hf, 1);
    if (timer_irq_o !== 1'b0) mismatch("timer_irq_o", 1'b0, timer_irq_o);
    n = 0;
    while ((timer_irq_o !== 1'b1) && (n < 25)) begin
      @(negedge clk_i);
      n++;
    end
    if (timer_irq_o !== 1'b1) fault("timer_irq_o did not rise within 25 cycles");
    write_word(CLINT_BASE + CLINT_MTIMECMP_HI_OFF, 32'hffff_ffff, 4'hf, 1);
    write_word(CLINT_BASE + CLINT_MTIMECMP_LO_OFF, 32'hffff_ffff, 4'hf, 1);
    idle(2);
    if (timer_irq_o !== 1'b0) mismatch("timer_irq_o", 1'b0, timer_irq_o);
  endtask

  task automatic soft_irq_check();
    data_t got;
    for (int v = 1; v >= 0; v--) begin
      write_word(CLINT_BASE + CLINT_MSIP_OFF, v, 4'hf, 1);
      if (sw_irq_o !== v[0]) mismatch("sw_irq_o", v[0], sw_irq_o);
      read_word(CLINT_BASE + CLINT_MSIP_OFF, 1, got);
      if (got !== data_t'(v)) mismatch("msip", v, got);
    end
  endtask

  task automatic unmapped_access(input logic we);
    int unsigned edges;
    drive_req(we, UNMAPPED, 32'h1234_5678, 4'hf, CTI_CLASSIC);
    await_response(edges);
    if (edges != 0) mismatch("err edges", 0, edges);
    if (wb_err_o !== 1'b1) mismatch("wb_err_o", 1'b1, wb_err_o);
    if (wb_ack_o !== 1'b0) mismatch("wb_ack_o", 1'b0, wb_ack_o);
    if (wb_dat_o !== 32'h0) mismatch("wb_dat_o", 32'h0, wb_dat_o);
    @(posedge clk_i);
    @(negedge clk_i);
    drive_idle();
  endtask

  // ======================================================================
  // Sequence and watchdog
  // ======================================================================

  initial begin
    mismatch_count = 0;
    fault_count    = 0;
    lfsr_q         = 32'h0d03a52b;
    rst_ni         = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    ram_byte_writes();
    single_read_latency();
    four_beat_burst();
    timer_irq_check();
    soft_irq_check();
    unmapped_access(1'b0);
    unmapped_access(1'b1);
    $display("Done: %0d value mismatches, %0d other errors", mismatch_count, fault_count);
    if ((mismatch_count == 0) && (fault_count == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- wb_clint.sv
`timescale 1ns/1ps

module wb_clint import ceres_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  wb_if.slave  bus,
  output logic timer_irq_o,
  output logic sw_irq_o
);

  logic        access;
  logic        wr_en;
  logic [15:0] off;

  mtime_t mtime_q;
  mtime_t mtime_d;
  mtime_t mtimecmp_q;
  mtime_t mtimecmp_d;
  logic   msip_q;
  logic   msip_d;
  data_t  rdata_d;
  data_t  rdata_q;
  logic   ack_q;
  logic   timer_irq_q;

  // Byte-lane merge of a write into an old word
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, sel_t sel);
    data_t res;
    res = old_w;
    for (int b = 0; b < $bits(sel_t); b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // A held request is served once
  assign access = bus.cyc && bus.stb && !ack_q;
  assign wr_en  = access && bus.we;
  assign off    = bus.adr[15:0];

  // ======================================================================
  // Register updates
  // ======================================================================

  always_comb begin
    // Free-running count unless software writes mtime
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    msip_d     = msip_q;
    if (wr_en) begin
      case (off)
        CLINT_MSIP_OFF:        msip_d = bus.sel[0] ? bus.dat_w[0] : msip_q;
        CLINT_MTIMECMP_LO_OFF: mtimecmp_d[31:0] = merge_bytes(mtimecmp_q[31:0], bus.dat_w, bus.sel);
        CLINT_MTIMECMP_HI_OFF: mtimecmp_d[63:32] = merge_bytes(mtimecmp_q[63:32], bus.dat_w, bus.sel);
        CLINT_MTIME_LO_OFF:    mtime_d = {mtime_q[63:32], merge_bytes(mtime_q[31:0], bus.dat_w, bus.sel)};
        CLINT_MTIME_HI_OFF:    mtime_d = {merge_bytes(mtime_q[63:32], bus.dat_w, bus.sel), mtime_q[31:0]};
        default: ;
      endcase
    end
  end

  // Read mux, holes read as zero
  always_comb begin
    case (off)
      CLINT_MSIP_OFF:        rdata_d = {31'd0, msip_q};
      CLINT_MTIMECMP_LO_OFF: rdata_d = mtimecmp_q[31:0];
      CLINT_MTIMECMP_HI_OFF: rdata_d = mtimecmp_q[63:32];
      CLINT_MTIME_LO_OFF:    rdata_d = mtime_q[31:0];
      CLINT_MTIME_HI_OFF:    rdata_d = mtime_q[63:32];
      default:               rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      ack_q       <= 1'b0;
      timer_irq_q <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      msip_q      <= msip_d;
      ack_q       <= access;
      // Level interrupt, one cycle behind the compare
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.dat_r   = rdata_q;
  assign bus.ack     = ack_q;
  assign bus.err     = 1'b0;
  assign timer_irq_o = timer_irq_q;
  assign sw_irq_o    = msip_q;

endmodule

//--- wb_decoder.sv
`timescale 1ns/1ps

module wb_decoder import ceres_pkg::*; (
  wb_if.slave  m_bus,
  wb_if.master ram_bus,
  wb_if.master clint_bus
);

  logic [3:0] region;
  logic       ram_hit;
  logic       clint_hit;
  logic       m_req;

  // Top nibble picks the slave
  assign region    = m_bus.adr[31:28];
  assign ram_hit   = (region == RAM_REGION);
  assign clint_hit = (region == CLINT_REGION);
  assign m_req     = m_bus.cyc && m_bus.stb;

  // ======================================================================
  // Request fan-out
  // ======================================================================

  // Only stb is steered, everything else goes to both slaves
  assign ram_bus.cyc   = m_bus.cyc;
  assign ram_bus.stb   = m_bus.stb && ram_hit;
  assign ram_bus.we    = m_bus.we;
  assign ram_bus.adr   = m_bus.adr;
  assign ram_bus.dat_w = m_bus.dat_w;
  assign ram_bus.sel   = m_bus.sel;
  assign ram_bus.cti   = m_bus.cti;

  assign clint_bus.cyc   = m_bus.cyc;
  assign clint_bus.stb   = m_bus.stb && clint_hit;
  assign clint_bus.we    = m_bus.we;
  assign clint_bus.adr   = m_bus.adr;
  assign clint_bus.dat_w = m_bus.dat_w;
  assign clint_bus.sel   = m_bus.sel;
  assign clint_bus.cti   = m_bus.cti;

  // ======================================================================
  // Response merge
  // ======================================================================

  always_comb begin
    m_bus.dat_r = '0;
    m_bus.ack   = 1'b0;
    m_bus.err   = 1'b0;
    if (ram_hit) begin
      m_bus.dat_r = ram_bus.dat_r;
      m_bus.ack   = ram_bus.ack;
      m_bus.err   = ram_bus.err;
    end else if (clint_hit) begin
      m_bus.dat_r = clint_bus.dat_r;
      m_bus.ack   = clint_bus.ack;
      m_bus.err   = clint_bus.err;
    end else begin
      // Unmapped, answer with err in the same cycle
      m_bus.err = m_req;
    end
  end

endmodule

//--- wb_if.sv
`timescale 1ns/1ps

interface wb_if import ceres_pkg::*; ();

  // Request side, master to slave
  logic  cyc;
  logic  stb;
  logic  we;
  addr_t adr;
  data_t dat_w;
  sel_t  sel;
  cti_t  cti;

  // Response side, slave to master
  data_t dat_r;
  logic  ack;
  logic  err;

  modport master (
    output cyc, stb, we, adr, dat_w, sel, cti,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w, sel, cti,
    output dat_r, ack, err
  );

endinterface

//--- wb_ram_adapter.sv
`timescale 1ns/1ps

module wb_ram_adapter import ceres_pkg::*; #(
  parameter int unsigned RAM_LINES   = 256,
  parameter int unsigned RAM_LATENCY = 4
) (
  input logic clk_i,
  input logic rst_ni,
  wb_if.slave bus
);

  localparam int unsigned IDX_W  = $clog2(RAM_LINES);
  localparam int unsigned WOFF_W = $clog2(WORDS_PER_LINE);
  localparam int unsigned WORD_W = $bits(data_t);
  localparam int unsigned SEL_W  = $bits(sel_t);

  burst_state_e state_q;
  burst_state_e state_d;

  logic              req;
  logic              rd_req;
  logic              wr_req;
  logic [IDX_W-1:0]  line_idx;
  logic [WOFF_W-1:0] word_off;

  line_t      wr_line;
  line_strb_t wr_strb;
  line_t      rd_line;
  line_t      buf_q;
  line_t      src_line;

  // Read latency tracking
  logic                   rd_en_q;
  logic [RAM_LATENCY-1:0] lat_q;
  logic                   fetch_ack_q;
  logic                   burst_ack;
  logic                   wr_ack;

  assign req    = bus.cyc && bus.stb;
  assign rd_req = req && !bus.we;
  assign wr_req = req && bus.we;

  // Line index above the byte offset, word index inside the line
  assign line_idx = bus.adr[LINE_OFFSET_W +: IDX_W];
  assign word_off = bus.adr[2 +: WOFF_W];

  // ======================================================================
  // Write path
  // ======================================================================

  // Word copied to every slot, strobes pick the real one
  assign wr_line = {WORDS_PER_LINE{bus.dat_w}};

  always_comb begin
    wr_strb = '0;
    if (wr_req) begin
      wr_strb[word_off*SEL_W +: SEL_W] = bus.sel;
    end
  end

  line_ram #(
    .RAM_LINES (RAM_LINES)
  ) u_line_ram (
    .clk_i      (clk_i),
    .line_idx_i (line_idx),
    .wdata_i    (wr_line),
    .wstrb_i    (wr_strb),
    .rd_en_i    (rd_en_q),
    .rdata_o    (rd_line)
  );

  // ======================================================================
  // Read FSM
  // ======================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (rd_req) begin
          state_d = FETCH;
        end
      end
      FETCH: begin
        // First beat done, stay on the line if more beats follow
        if (fetch_ack_q) begin
          state_d = (bus.cti == CTI_INCR) ? BURST : IDLE;
        end
      end
      BURST: begin
        if (burst_ack && (bus.cti == CTI_EOB)) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      rd_en_q     <= 1'b0;
      lat_q       <= '0;
      fetch_ack_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // One read per fetch, only launched from IDLE
      rd_en_q     <= (state_q == IDLE) && rd_req;
      lat_q       <= {lat_q[RAM_LATENCY-2:0], rd_en_q};
      fetch_ack_q <= lat_q[RAM_LATENCY-1];
    end
  end

  // Line buffer for later burst beats
  always_ff @(posedge clk_i) begin
    if (fetch_ack_q) begin
      buf_q <= rd_line;
    end
  end

  // ======================================================================
  // Response
  // ======================================================================

  assign wr_ack    = wr_req;
  assign burst_ack = (state_q == BURST) && rd_req;

  assign src_line  = (state_q == BURST) ? buf_q : rd_line;
  assign bus.dat_r = src_line[word_off*WORD_W +: WORD_W];
  assign bus.ack   = wr_ack || fetch_ack_q || burst_ack;
  assign bus.err   = 1'b0;

endmodule
